// File: logic/rename_types_pkg.sv
package rename_types_pkg;

	// physical register numbers cover up to 64 registers
	localparam int PREG_BITS = 6;

	// architectural register numbers cover up to 16 registers
	localparam int AREG_BITS = 4;

	// physical register tag handed out by the free list
	typedef logic [PREG_BITS-1:0] phys_reg_t;

	// architectural register index as seen by the decoder
	typedef logic [AREG_BITS-1:0] arch_reg_t;

endpackage

// File: logic/rename_msg_pkg.sv
package rename_msg_pkg;

	import rename_types_pkg::*;

	// one instruction offered by decode
	typedef struct packed {
		logic      valid;
		logic      has_dest;
		logic      is_branch;
		arch_reg_t dest;
	} dispatch_req_t;

	// rename result, new_reg is T and old_reg is T_old
	typedef struct packed {
		logic      valid;
		phys_reg_t new_reg;
		phys_reg_t old_reg;
	} rename_rsp_t;

	// one reorder buffer record
	typedef struct packed {
		logic      has_dest;
		logic      is_branch;
		phys_reg_t new_reg;
		phys_reg_t old_reg;
	} rob_entry_t;

	// register released by retirement
	typedef struct packed {
		logic      valid;
		phys_reg_t freed;
	} retire_msg_t;

	// branch outcome from execute
	typedef struct packed {
		logic valid;
		logic mispredict;
	} branch_res_t;

endpackage

// File: logic/free_list.sv
`timescale 1ns/1ps

module free_list import rename_types_pkg::*, rename_msg_pkg::*; #(
	parameter int NUM_ARCH_REG = 8,
	parameter int NUM_PHYS_REG = 24,
	localparam int FL_SIZE = NUM_PHYS_REG - NUM_ARCH_REG,
	localparam int CNT_BITS = $clog2(FL_SIZE + 1)
) (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      pop,
	input  retire_msg_t               push,
	input  logic                      restore,
	input  phys_reg_t [FL_SIZE-1:0]   restore_list,
	input  logic [CNT_BITS-1:0]       restore_tail,
	output phys_reg_t                 head_reg,
	output logic [CNT_BITS-1:0]       free_count,
	output phys_reg_t [FL_SIZE-1:0]   list,
	output logic                      empty
);

	// slot index width, at least one bit
	localparam int IDX_BITS = (FL_SIZE > 1) ? $clog2(FL_SIZE) : 1;

	// entry 0 is the head, valid entries are 0 .. tail_q-1
	phys_reg_t [FL_SIZE-1:0] list_q;
	phys_reg_t [FL_SIZE-1:0] next_list;

	// tail_q doubles as the number of free registers
	logic [CNT_BITS-1:0] tail_q;
	logic [CNT_BITS-1:0] next_tail;

	assign head_reg   = list_q[0];
	assign free_count = tail_q;
	assign empty      = (tail_q == '0);

	// contents after this edge, the checkpoint captures these on a branch
	assign list = next_list;

	always_comb begin
		next_list = list_q;
		next_tail = tail_q;
		if (restore) begin
			// misprediction wins over any push or pop this cycle
			next_list = restore_list;
			next_tail = restore_tail;
		end else begin
			if (pop) begin
				// everything moves one slot toward the head
				for (int i = 0; i < FL_SIZE - 1; i++) begin
					next_list[i] = list_q[i + 1];
				end
				next_tail = tail_q - CNT_BITS'(1);
			end
			if (push.valid) begin
				// lands at tail, or tail-1 when a pop shifted the queue
				next_list[next_tail[IDX_BITS-1:0]] = push.freed;
				next_tail = next_tail + CNT_BITS'(1);
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			// map table owns 0 .. NUM_ARCH_REG-1, the rest start out free
			for (int i = 0; i < FL_SIZE; i++) begin
				list_q[i] <= phys_reg_t'(NUM_ARCH_REG + i);
			end
			tail_q <= CNT_BITS'(FL_SIZE);
		end else begin
			list_q <= next_list;
			tail_q <= next_tail;
		end
	end

endmodule

// File: logic/map_table.sv
`timescale 1ns/1ps

module map_table import rename_types_pkg::*, rename_msg_pkg::*; #(
	parameter int NUM_ARCH_REG = 8
) (
	input  logic                         clock,
	input  logic                         reset,
	input  dispatch_req_t                req,
	input  logic                         grant,
	input  phys_reg_t                    new_reg,
	input  logic                         restore,
	input  phys_reg_t [NUM_ARCH_REG-1:0] restore_map,
	output rename_rsp_t                  rsp,
	output phys_reg_t [NUM_ARCH_REG-1:0] map
);

	// index width for the architectural registers in use
	localparam int A_IDX = (NUM_ARCH_REG > 1) ? $clog2(NUM_ARCH_REG) : 1;

	phys_reg_t [NUM_ARCH_REG-1:0] map_q;
	phys_reg_t [NUM_ARCH_REG-1:0] next_map;

	logic [A_IDX-1:0] dest_idx;
	logic             write_en;

	// only the low bits select an entry, dest stays below NUM_ARCH_REG
	assign dest_idx = req.dest[A_IDX-1:0];
	assign write_en = grant & req.has_dest;

	// T comes straight from the free list head, T_old from the current map
	assign rsp.valid   = write_en;
	assign rsp.new_reg = new_reg;
	assign rsp.old_reg = map_q[dest_idx];

	always_comb begin
		next_map = map_q;
		if (restore) begin
			next_map = restore_map;
		end else if (write_en) begin
			next_map[dest_idx] = new_reg;
		end
	end

	// post-dispatch map, captured alongside a branch
	assign map = next_map;

	always_ff @(posedge clock) begin
		if (reset) begin
			// identity mapping out of reset
			for (int i = 0; i < NUM_ARCH_REG; i++) begin
				map_q[i] <= phys_reg_t'(i);
			end
		end else begin
			map_q <= next_map;
		end
	end

endmodule

// File: logic/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer import rename_msg_pkg::*; #(
	parameter int ROB_SIZE = 16,
	localparam int PTR_BITS = (ROB_SIZE > 1) ? $clog2(ROB_SIZE) : 1,
	localparam int CNT_BITS = $clog2(ROB_SIZE + 1)
) (
	input  logic                clock,
	input  logic                reset,
	input  logic                grant,
	input  rob_entry_t          entry,
	input  logic                retire,
	input  logic                branch_pending,
	input  logic                squash,
	input  logic [PTR_BITS-1:0] squash_tail,
	output retire_msg_t         freed,
	output logic                full,
	output logic [PTR_BITS-1:0] alloc_tail,
	output logic [CNT_BITS-1:0] count
);

	// record storage, written at tail and read at head
	rob_entry_t [ROB_SIZE-1:0] entries;

	logic [PTR_BITS-1:0] head_q;
	logic [PTR_BITS-1:0] tail_q;
	logic [CNT_BITS-1:0] count_q;

	// slot of the unresolved branch
	logic [PTR_BITS-1:0] branch_idx_q;

	logic                do_retire;
	logic [PTR_BITS-1:0] head_n;
	logic [CNT_BITS-1:0] squash_count;

	// circular increment, ROB_SIZE need not be a power of two
	function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] p);
		return (p == PTR_BITS'(ROB_SIZE - 1)) ? '0 : p + PTR_BITS'(1);
	endfunction

	// the head may not leave while it is the branch still in flight
	assign do_retire = retire && (count_q != '0) &&
		!(branch_pending && (head_q == branch_idx_q));

	// T_old goes back to the free list only for destination writers
	assign freed.valid = do_retire & entries[head_q].has_dest;
	assign freed.freed = entries[head_q].old_reg;

	assign full       = (count_q == CNT_BITS'(ROB_SIZE));
	assign alloc_tail = tail_q;
	assign count      = count_q;

	assign head_n = do_retire ? ptr_inc(head_q) : head_q;

	// entries left after a squash run from the new head up to the branch
	always_comb begin
		if (squash_tail >= head_n) begin
			squash_count = CNT_BITS'(squash_tail) - CNT_BITS'(head_n);
		end else begin
			squash_count = CNT_BITS'(squash_tail) + CNT_BITS'(ROB_SIZE) - CNT_BITS'(head_n);
		end
		// the branch itself is always kept, so zero distance means full
		if (squash_count == '0) begin
			squash_count = CNT_BITS'(ROB_SIZE);
		end
	end

	always_ff @(posedge clock) begin
		if (grant) begin
			entries[tail_q] <= entry;
		end
		if (grant && entry.is_branch) begin
			branch_idx_q <= tail_q;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			head_q  <= '0;
			tail_q  <= '0;
			count_q <= '0;
		end else begin
			head_q <= head_n;
			if (squash) begin
				// younger entries past the branch are dropped
				tail_q  <= squash_tail;
				count_q <= squash_count;
			end else begin
				if (grant) begin
					tail_q <= ptr_inc(tail_q);
				end
				count_q <= count_q + CNT_BITS'(grant) - CNT_BITS'(do_retire);
			end
		end
	end

endmodule

// File: logic/branch_checkpoint.sv
`timescale 1ns/1ps

module branch_checkpoint import rename_types_pkg::*, rename_msg_pkg::*; #(
	parameter int NUM_ARCH_REG = 8,
	parameter int NUM_PHYS_REG = 24,
	parameter int ROB_SIZE = 16,
	localparam int FL_SIZE = NUM_PHYS_REG - NUM_ARCH_REG,
	localparam int CNT_BITS = $clog2(FL_SIZE + 1),
	localparam int PTR_BITS = (ROB_SIZE > 1) ? $clog2(ROB_SIZE) : 1
) (
	input  logic                         clock,
	input  logic                         reset,
	input  logic                         capture,
	input  phys_reg_t [NUM_ARCH_REG-1:0] next_map,
	input  phys_reg_t [FL_SIZE-1:0]      next_list,
	input  logic [CNT_BITS-1:0]          next_tail,
	input  logic [PTR_BITS-1:0]          rob_tail,
	input  retire_msg_t                  freed,
	input  branch_res_t                  resolve,
	output logic                         busy,
	output logic                         restore,
	output phys_reg_t [NUM_ARCH_REG-1:0] restore_map,
	output phys_reg_t [FL_SIZE-1:0]      restore_list,
	output logic [CNT_BITS-1:0]          restore_tail,
	output logic [PTR_BITS-1:0]          restore_rob_tail
);

	localparam int IDX_BITS = (FL_SIZE > 1) ? $clog2(FL_SIZE) : 1;

	logic                         busy_q;
	phys_reg_t [NUM_ARCH_REG-1:0] saved_map;
	phys_reg_t [FL_SIZE-1:0]      saved_list;
	logic [CNT_BITS-1:0]          saved_tail;
	logic [PTR_BITS-1:0]          saved_rob_tail;

	// saved list with this cycle's retirement already appended
	phys_reg_t [FL_SIZE-1:0] app_list;
	logic [CNT_BITS-1:0]     app_tail;

	always_comb begin
		app_list = saved_list;
		app_tail = saved_tail;
		if (freed.valid) begin
			app_list[saved_tail[IDX_BITS-1:0]] = freed.freed;
			app_tail = saved_tail + CNT_BITS'(1);
		end
	end

	assign busy    = busy_q;
	assign restore = busy_q & resolve.valid & resolve.mispredict;

	assign restore_map      = saved_map;
	assign restore_list     = app_list;
	assign restore_tail     = app_tail;
	assign restore_rob_tail = saved_rob_tail;

	// payload copy, no reset needed
	always_ff @(posedge clock) begin
		if (capture) begin
			saved_map  <= next_map;
			saved_list <= next_list;
			saved_tail <= next_tail;
			// the slot just past the branch
			saved_rob_tail <= (rob_tail == PTR_BITS'(ROB_SIZE - 1)) ?
				'0 : rob_tail + PTR_BITS'(1);
		end else if (busy_q) begin
			// older instructions keep retiring, their T_old must survive a restore
			saved_list <= app_list;
			saved_tail <= app_tail;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			busy_q <= 1'b0;
		end else if (capture) begin
			busy_q <= 1'b1;
		end else if (resolve.valid) begin
			busy_q <= 1'b0;
		end
	end

endmodule

// File: logic/rename_stage.sv
`timescale 1ns/1ps

module rename_stage import rename_types_pkg::*, rename_msg_pkg::*; #(
	parameter int NUM_ARCH_REG = 8,
	parameter int NUM_PHYS_REG = 24,
	parameter int ROB_SIZE = 16,
	localparam int FL_SIZE = NUM_PHYS_REG - NUM_ARCH_REG,
	localparam int CNT_BITS = $clog2(FL_SIZE + 1)
) (
	input  logic                clock,
	input  logic                reset,
	input  dispatch_req_t       dispatch,
	input  logic                retire,
	input  branch_res_t         resolve,
	output rename_rsp_t         rename,
	output logic                stall,
	output retire_msg_t         freed,
	output logic [CNT_BITS-1:0] free_count
);

	localparam int PTR_BITS = (ROB_SIZE > 1) ? $clog2(ROB_SIZE) : 1;
	localparam int ROB_CNT_BITS = $clog2(ROB_SIZE + 1);

	logic grant;
	logic pop;
	logic capture;

	// free list side
	phys_reg_t                 fl_head;
	phys_reg_t [FL_SIZE-1:0]   fl_list;
	logic                      fl_empty;
	logic [CNT_BITS-1:0]       fl_next_tail;

	// map side
	phys_reg_t [NUM_ARCH_REG-1:0] next_map;

	// reorder buffer side
	rob_entry_t                 rob_entry;
	logic                       rob_full;
	logic [PTR_BITS-1:0]        rob_tail;
	// occupancy, observed by the bound properties
	logic [ROB_CNT_BITS-1:0]    rob_count;

	// checkpoint side
	logic                         cp_busy;
	logic                         cp_restore;
	phys_reg_t [NUM_ARCH_REG-1:0] cp_map;
	phys_reg_t [FL_SIZE-1:0]      cp_list;
	logic [CNT_BITS-1:0]          cp_tail;
	logic [PTR_BITS-1:0]          cp_rob_tail;

	// any structural hazard, or a misprediction being repaired this cycle
	assign stall = rob_full |
		(dispatch.has_dest & fl_empty) |
		(dispatch.is_branch & cp_busy) |
		(resolve.valid & resolve.mispredict);

	assign grant   = dispatch.valid & ~stall;
	assign pop     = grant & dispatch.has_dest;
	assign capture = grant & dispatch.is_branch;

	assign rob_entry.has_dest  = dispatch.has_dest;
	assign rob_entry.is_branch = dispatch.is_branch;
	assign rob_entry.new_reg   = fl_head;
	assign rob_entry.old_reg   = rename.old_reg;

	// free count the list will hold after this edge
	always_comb begin
		fl_next_tail = free_count;
		if (pop) begin
			fl_next_tail = fl_next_tail - CNT_BITS'(1);
		end
		if (freed.valid) begin
			fl_next_tail = fl_next_tail + CNT_BITS'(1);
		end
	end

	free_list #(
		.NUM_ARCH_REG(NUM_ARCH_REG),
		.NUM_PHYS_REG(NUM_PHYS_REG)
	) u_free_list (
		.clock        (clock),
		.reset        (reset),
		.pop          (pop),
		.push         (freed),
		.restore      (cp_restore),
		.restore_list (cp_list),
		.restore_tail (cp_tail),
		.head_reg     (fl_head),
		.free_count   (free_count),
		.list         (fl_list),
		.empty        (fl_empty)
	);

	map_table #(
		.NUM_ARCH_REG(NUM_ARCH_REG)
	) u_map_table (
		.clock       (clock),
		.reset       (reset),
		.req         (dispatch),
		.grant       (grant),
		.new_reg     (fl_head),
		.restore     (cp_restore),
		.restore_map (cp_map),
		.rsp         (rename),
		.map         (next_map)
	);

	reorder_buffer #(
		.ROB_SIZE(ROB_SIZE)
	) u_reorder_buffer (
		.clock          (clock),
		.reset          (reset),
		.grant          (grant),
		.entry          (rob_entry),
		.retire         (retire),
		.branch_pending (cp_busy),
		.squash         (cp_restore),
		.squash_tail    (cp_rob_tail),
		.freed          (freed),
		.full           (rob_full),
		.alloc_tail     (rob_tail),
		.count          (rob_count)
	);

	branch_checkpoint #(
		.NUM_ARCH_REG(NUM_ARCH_REG),
		.NUM_PHYS_REG(NUM_PHYS_REG),
		.ROB_SIZE(ROB_SIZE)
	) u_branch_checkpoint (
		.clock            (clock),
		.reset            (reset),
		.capture          (capture),
		.next_map         (next_map),
		.next_list        (fl_list),
		.next_tail        (fl_next_tail),
		.rob_tail         (rob_tail),
		.freed            (freed),
		.resolve          (resolve),
		.busy             (cp_busy),
		.restore          (cp_restore),
		.restore_map      (cp_map),
		.restore_list     (cp_list),
		.restore_tail     (cp_tail),
		.restore_rob_tail (cp_rob_tail)
	);

endmodule

// File: bench/rename_stage_props.sv
`timescale 1ns/1ps

module rename_stage_props import rename_msg_pkg::*; #(
	parameter int FL_SIZE = 16,
	parameter int ROB_SIZE = 16,
	localparam int CNT_BITS = $clog2(FL_SIZE + 1),
	localparam int PTR_BITS = (ROB_SIZE > 1) ? $clog2(ROB_SIZE) : 1,
	localparam int ROB_CNT_BITS = $clog2(ROB_SIZE + 1)
) (
	input logic                      clock,
	input logic                      reset,
	input dispatch_req_t             dispatch,
	input logic                      stall,
	input retire_msg_t               freed,
	input logic [CNT_BITS-1:0]       free_count,
	input logic [ROB_CNT_BITS-1:0]   rob_count,
	input logic [PTR_BITS-1:0]       rob_head,
	input rob_entry_t [ROB_SIZE-1:0] rob_entries,
	input logic                      restore
);

	// read by the testbench when it decides the verdict
	int fail_count = 0;

	// writers still in flight, each holding its T_old out of the free list
	int dest_count;

	always_comb begin
		dest_count = 0;
		for (int i = 0; i < ROB_SIZE; i++) begin
			if (i < int'(rob_count)) begin
				if (rob_entries[(int'(rob_head) + i) % ROB_SIZE].has_dest) begin
					dest_count++;
				end
			end
		end
	end

	// no register is lost or duplicated between the free list and the ROB
	conserved_regs: assert property (@(posedge clock) disable iff (reset)
		!restore |-> (int'(free_count) + dest_count == FL_SIZE))
	else begin
		$error("free registers and in-flight destinations do not add up");
		fail_count++;
	end

	// a writer never gets past an empty free list
	empty_list_stalls: assert property (@(posedge clock) disable iff (reset)
		(dispatch.valid && dispatch.has_dest && free_count == '0) |-> stall)
	else begin
		$error("destination request not stalled on an empty free list");
		fail_count++;
	end

	// nothing to free when the ROB holds no instruction
	no_free_when_empty: assert property (@(posedge clock) disable iff (reset)
		freed.valid |-> (rob_count != '0))
	else begin
		$error("register freed while the reorder buffer is empty");
		fail_count++;
	end

endmodule

// File: bench/rename_stage_tb.sv
`timescale 1ns/1ps

module rename_stage_tb
	import rename_types_pkg::*, rename_msg_pkg::*;
();

	localparam int NUM_ARCH_REG = 8;
	localparam int NUM_PHYS_REG = 24;
	// larger than the free list, so the list can drain before the ROB fills
	localparam int ROB_SIZE = 20;
	localparam int FL_SIZE = NUM_PHYS_REG - NUM_ARCH_REG;
	localparam int CNT_BITS = $clog2(FL_SIZE + 1);
	localparam int RAND_CYCLES = 60;
	// rough length of each test, drains take up to ROB_SIZE cycles
	localparam int STIM_CYCLES = 12 + (ROB_SIZE + RAND_CYCLES) +
		(2 * ROB_SIZE + FL_SIZE + 10) + (ROB_SIZE + 24) + (ROB_SIZE + 12);
	localparam int CYCLE_LIMIT = 4 * STIM_CYCLES;

	logic                clock = 1'b0;
	logic                reset;
	dispatch_req_t       dispatch;
	logic                retire;
	branch_res_t         resolve;
	rename_rsp_t         rename;
	logic                stall;
	retire_msg_t         freed;
	logic [CNT_BITS-1:0] free_count;

	// reference model state
	phys_reg_t  model_map [NUM_ARCH_REG];
	phys_reg_t  cp_map [NUM_ARCH_REG];
	phys_reg_t  pre_map [NUM_ARCH_REG];
	phys_reg_t  free_q [$];
	phys_reg_t  cp_free [$];
	rob_entry_t rob_q [$];
	logic       cp_valid;
	// ROB records up to and including the pending branch
	int         cp_keep;
	int         cp_start;
	int         cp_retired;

	int          errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          cycle_count = 0;
	logic [31:0] lcg_state = 32'heba83863;

	rename_stage #(
		.NUM_ARCH_REG(NUM_ARCH_REG),
		.NUM_PHYS_REG(NUM_PHYS_REG),
		.ROB_SIZE(ROB_SIZE)
	) UUT (
		.clock      (clock),
		.reset      (reset),
		.dispatch   (dispatch),
		.retire     (retire),
		.resolve    (resolve),
		.rename     (rename),
		.stall      (stall),
		.freed      (freed),
		.free_count (free_count)
	);

	bind rename_stage rename_stage_props #(
		.FL_SIZE(FL_SIZE),
		.ROB_SIZE(ROB_SIZE)
	) u_props (
		.clock       (clock),
		.reset       (reset),
		.dispatch    (dispatch),
		.stall       (stall),
		.freed       (freed),
		.free_count  (free_count),
		.rob_count   (rob_count),
		.rob_head    (u_reorder_buffer.head_q),
		.rob_entries (u_reorder_buffer.entries),
		.restore     (cp_restore)
	);

	always #10 clock = ~clock;

	// hard stop in case a request is never granted
	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT) begin
			$display("timeout: run went past %0d cycles without finishing", CYCLE_LIMIT);
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic arch_reg_t random_dest();
		logic [31:0] rnd;
		rnd = next_random();
		return arch_reg_t'(rnd[27:20] % NUM_ARCH_REG);
	endfunction

	function automatic dispatch_req_t make_req(logic valid, logic has_dest, logic is_branch,
			arch_reg_t dest);
		dispatch_req_t d;
		d.valid     = valid;
		d.has_dest  = has_dest;
		d.is_branch = is_branch;
		d.dest      = dest;
		return d;
	endfunction

	function automatic branch_res_t make_res(logic valid, logic mispredict);
		branch_res_t b;
		b.valid      = valid;
		b.mispredict = mispredict;
		return b;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			$display("ERROR: %s is 0x%0h, expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	// compare this cycle's outputs, then advance the model past the next edge
	task automatic check_and_update(output logic granted);
		logic       old_cp;
		logic       exp_stall;
		logic       exp_grant;
		logic       exp_retire;
		rob_entry_t ent;
		rob_entry_t head;
		old_cp = cp_valid;
		exp_stall = (rob_q.size() == ROB_SIZE) ||
			(dispatch.has_dest && free_q.size() == 0) ||
			(dispatch.is_branch && old_cp) || (resolve.valid && resolve.mispredict);
		exp_grant = dispatch.valid && !exp_stall;
		// the pending branch blocks retirement once it reaches the head
		exp_retire = retire && rob_q.size() > 0 && !(old_cp && cp_keep == 1);
		check_value("stall", 32'(stall), 32'(exp_stall));
		check_value("free_count", 32'(free_count), free_q.size());
		check_value("rename.valid", 32'(rename.valid), 32'(exp_grant && dispatch.has_dest));
		ent.has_dest  = dispatch.has_dest;
		ent.is_branch = dispatch.is_branch;
		ent.new_reg   = (free_q.size() > 0) ? free_q[0] : '0;
		ent.old_reg   = model_map[int'(dispatch.dest)];
		if (exp_grant && dispatch.has_dest) begin
			check_value("rename.new_reg", 32'(rename.new_reg), 32'(ent.new_reg));
			check_value("rename.old_reg", 32'(rename.old_reg), 32'(ent.old_reg));
		end
		if (exp_retire) begin
			head = rob_q.pop_front();
			check_value("freed.valid", 32'(freed.valid), 32'(head.has_dest));
			if (head.has_dest) begin
				check_value("freed.freed", 32'(freed.freed), 32'(head.old_reg));
				free_q.push_back(head.old_reg);
				if (old_cp) begin
					cp_free.push_back(head.old_reg);
					cp_retired++;
				end
			end
			if (old_cp) begin
				cp_keep--;
			end
		end else begin
			check_value("freed.valid", 32'(freed.valid), 32'(0));
		end
		if (exp_grant) begin
			if (dispatch.has_dest) begin
				void'(free_q.pop_front());
				model_map[int'(dispatch.dest)] = ent.new_reg;
			end
			rob_q.push_back(ent);
			if (dispatch.is_branch) begin
				cp_valid   = 1'b1;
				cp_map     = model_map;
				cp_free    = free_q;
				cp_keep    = rob_q.size();
				cp_start   = free_q.size();
				cp_retired = 0;
			end
		end
		if (resolve.valid && old_cp) begin
			if (resolve.mispredict) begin
				model_map = cp_map;
				free_q    = cp_free;
				while (rob_q.size() > cp_keep) begin
					void'(rob_q.pop_back());
				end
			end
			cp_valid = 1'b0;
		end
		granted = exp_grant;
	endtask

	task automatic run_cycle(input dispatch_req_t d, input logic r, input branch_res_t b,
			output logic granted);
		@(posedge clock);
		#1;
		dispatch = d;
		retire   = r;
		resolve  = b;
		// outputs settle well before the falling edge
		@(negedge clock);
		check_and_update(granted);
	endtask

	// hold one request until the DUT takes it
	task automatic issue(input logic has_dest, input logic is_branch, input arch_reg_t dest,
			input logic r);
		logic granted;
		granted = 1'b0;
		while (!granted) begin
			run_cycle(make_req(1'b1, has_dest, is_branch, dest), r, '0, granted);
		end
	endtask

	task automatic drain_rob();
		logic granted;
		while (rob_q.size() > 0) begin
			run_cycle('0, 1'b1, '0, granted);
		end
	endtask

	task automatic end_test(input string name, input int start_errors);
		tests_run++;
		if (errors == start_errors) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errors - start_errors);
		end
	endtask

	initial begin
		int          start;
		int          prop_failures;
		logic        granted;
		logic [31:0] rnd;
		phys_reg_t   prev_t;
		phys_reg_t   kept_t;
		arch_reg_t   kept_reg;
		int          held_count;
		reset    = 1'b1;
		dispatch = '0;
		retire   = 1'b0;
		resolve  = '0;
		// model starts from the reset mapping
		for (int i = 0; i < NUM_ARCH_REG; i++) begin
			model_map[i] = phys_reg_t'(i);
		end
		for (int i = NUM_ARCH_REG; i < NUM_PHYS_REG; i++) begin
			free_q.push_back(phys_reg_t'(i));
		end
		cp_valid = 1'b0;
		cp_keep  = 0;
		repeat (2) @(posedge clock);
		#1 reset = 1'b0;

		// first renames take the lowest free registers
		start = errors;
		run_cycle('0, 1'b0, '0, granted);
		check_value("free_count", 32'(free_count), FL_SIZE);
		for (int i = 0; i < 3; i++) begin
			issue(1'b1, 1'b0, arch_reg_t'(i), 1'b0);
			check_value("rename.new_reg", 32'(rename.new_reg), NUM_ARCH_REG + i);
			check_value("rename.old_reg", 32'(rename.old_reg), i);
		end
		end_test("reset_state", start);

		// each write to r5 sees the T of the write before it
		start = errors;
		prev_t = phys_reg_t'(5);
		for (int i = 0; i < 6; i++) begin
			issue(1'b1, 1'b0, arch_reg_t'(5), 1'b0);
			check_value("rename.old_reg", 32'(rename.old_reg), 32'(prev_t));
			prev_t = model_map[5];
		end
		end_test("rename_chain", start);

		// freed registers come back in retirement order
		start = errors;
		drain_rob();
		for (int i = 0; i < RAND_CYCLES; i++) begin
			rnd = next_random();
			run_cycle(make_req(rnd[20:19] != 2'b00, 1'b1, 1'b0,
				arch_reg_t'(rnd[27:24] % NUM_ARCH_REG)), rnd[29], '0, granted);
		end
		end_test("fifo_reuse", start);

		start = errors;
		drain_rob();
		for (int i = 0; i < FL_SIZE; i++) begin
			issue(1'b1, 1'b0, random_dest(), 1'b0);
		end
		held_count = free_q.size();
		run_cycle(make_req(1'b1, 1'b1, 1'b0, random_dest()), 1'b0, '0, granted);
		check_value("stall", 32'(stall), 32'(1));
		// a branch needs no register and still gets through
		run_cycle(make_req(1'b1, 1'b0, 1'b1, '0), 1'b0, '0, granted);
		check_value("stall", 32'(stall), 32'(0));
		run_cycle('0, 1'b0, make_res(1'b1, 1'b0), granted);
		while (rob_q.size() < ROB_SIZE) begin
			issue(1'b0, 1'b0, '0, 1'b0);
		end
		run_cycle(make_req(1'b1, 1'b1, 1'b0, random_dest()), 1'b0, '0, granted);
		check_value("stall", 32'(stall), 32'(1));
		run_cycle(make_req(1'b1, 1'b0, 1'b1, '0), 1'b0, '0, granted);
		check_value("stall", 32'(stall), 32'(1));
		run_cycle(make_req(1'b1, 1'b0, 1'b0, '0), 1'b0, '0, granted);
		check_value("stall", 32'(stall), 32'(1));
		check_value("free_count", 32'(free_count), 32'(held_count));
		// retirement frees a slot and a register, then the writer goes
		issue(1'b1, 1'b0, random_dest(), 1'b1);
		drain_rob();
		end_test("stall_backpressure", start);

		start = errors;
		for (int i = 0; i < 4; i++) begin
			issue(1'b1, 1'b0, arch_reg_t'(i + 3), 1'b0);
		end
		pre_map = model_map;
		issue(1'b0, 1'b1, '0, 1'b0);
		for (int i = 0; i < 5; i++) begin
			issue(1'b1, 1'b0, random_dest(), logic'(i < 3));
		end
		// the last older writer retires in the mispredict cycle itself
		run_cycle('0, 1'b1, make_res(1'b1, 1'b1), granted);
		run_cycle('0, 1'b0, '0, granted);
		check_value("free_count", 32'(free_count), cp_start + cp_retired);
		for (int r = 0; r < NUM_ARCH_REG; r++) begin
			issue(1'b1, 1'b0, arch_reg_t'(r), 1'b0);
			check_value("rename.old_reg", 32'(rename.old_reg), 32'(pre_map[r]));
		end
		drain_rob();
		end_test("mispredict_recovery", start);

		start = errors;
		issue(1'b0, 1'b1, '0, 1'b0);
		for (int i = 0; i < 3; i++) begin
			issue(1'b1, 1'b0, random_dest(), 1'b0);
		end
		kept_reg = dispatch.dest;
		kept_t   = model_map[int'(kept_reg)];
		run_cycle('0, 1'b0, make_res(1'b1, 1'b0), granted);
		run_cycle(make_req(1'b1, 1'b0, 1'b1, '0), 1'b0, '0, granted);
		check_value("stall", 32'(stall), 32'(0));
		issue(1'b1, 1'b0, kept_reg, 1'b0);
		check_value("rename.old_reg", 32'(rename.old_reg), 32'(kept_t));
		rnd = next_random();
		run_cycle('0, 1'b0, make_res(1'b1, rnd[16]), granted);
		drain_rob();
		end_test("correct_resolution", start);

		prop_failures = UUT.u_props.fail_count;
		$display("%0d tests, %0d failed, %0d check errors, %0d property failures",
			tests_run, tests_failed, errors, prop_failures);
		if (errors == 0 && tests_failed == 0 && prop_failures == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: filelist.f
logic/rename_types_pkg.sv
logic/rename_msg_pkg.sv
logic/free_list.sv
logic/map_table.sv
logic/reorder_buffer.sv
logic/branch_checkpoint.sv
logic/rename_stage.sv
bench/rename_stage_props.sv
bench/rename_stage_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= rename_stage_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; \
	status=$$?; \
	cat $(LOG); \
	if grep -q "TEST FAILED" $(LOG); then exit 1; fi; \
	if [ $$status -ne 0 ]; then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
